/* design/axi_regs_pkg.sv */
`default_nettype none

package axi_regs_pkg;

  localparam int data_width      = 32;
  localparam int addr_width      = 7;
  localparam int strb_width      = data_width / 8;        // One strobe bit per byte lane
  localparam int addr_lsb        = 2;                     // Word aligned, bits 1:0 ignored
  localparam int reg_index_width = 5;
  localparam int num_regs        = 1 << reg_index_width;

  typedef logic [data_width-1:0]      data_t;
  typedef logic [addr_width-1:0]      addr_t;
  typedef logic [strb_width-1:0]      strb_t;
  typedef logic [reg_index_width-1:0] reg_index_t;

  // AXI response codes
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

/* design/reg_write_channel.sv */
`default_nettype none

module reg_write_channel (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  axi_regs_pkg::addr_t     s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  axi_regs_pkg::data_t     s_axi_wdata,
  input  axi_regs_pkg::strb_t     s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output axi_regs_pkg::axi_resp_e s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  output logic                    wr_en,
  output axi_regs_pkg::reg_index_t wr_index,
  output axi_regs_pkg::data_t     wr_data,
  output axi_regs_pkg::strb_t     wr_strb
);

  import axi_regs_pkg::*;

  logic aw_accept;

  // Address and data must arrive together, and no response may be stuck
  assign aw_accept = s_axi_awvalid && s_axi_wvalid && !s_axi_awready &&
                     (!s_axi_bvalid || s_axi_bready);

  // AWREADY and WREADY pulse together for one cycle
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
    end else begin
      s_axi_awready <= aw_accept;
      s_axi_wready  <= aw_accept;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (aw_accept) begin
      wr_index <= s_axi_awaddr[addr_lsb +: reg_index_width];  // Word index
    end
  end

  // Both handshakes complete on the same edge
  assign wr_en   = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;
  assign wr_data = s_axi_wdata;
  assign wr_strb = s_axi_wstrb;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_bvalid <= 1'b0;
    end else if (wr_en) begin
      s_axi_bvalid <= 1'b1;
    end else if (s_axi_bready) begin
      s_axi_bvalid <= 1'b0;                  // Response taken
    end
  end

  assign s_axi_bresp = resp_okay;

endmodule

`default_nettype wire

/* design/reg_bank.sv */
`default_nettype none

module reg_bank (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic                     wr_en,
  input  axi_regs_pkg::reg_index_t wr_index,
  input  axi_regs_pkg::data_t      wr_data,
  input  axi_regs_pkg::strb_t      wr_strb,
  input  axi_regs_pkg::reg_index_t rd_index,
  output axi_regs_pkg::data_t      rd_data
);

  import axi_regs_pkg::*;

  data_t regs [num_regs];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < strb_width; b++) begin
        if (wr_strb[b]) begin
          regs[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];  // Only enabled lanes
        end
      end
    end
  end

  assign rd_data = regs[rd_index];           // Registered later in the read channel

endmodule

`default_nettype wire

/* design/reg_read_channel.sv */
`default_nettype none

module reg_read_channel (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  axi_regs_pkg::addr_t      s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  output axi_regs_pkg::data_t      s_axi_rdata,
  output axi_regs_pkg::axi_resp_e  s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready,
  output axi_regs_pkg::reg_index_t rd_index,
  input  axi_regs_pkg::data_t      rd_data
);

  import axi_regs_pkg::*;

  logic ar_accept;
  logic ar_done;

  assign ar_accept = s_axi_arvalid && !s_axi_arready &&
                     (!s_axi_rvalid || s_axi_rready);
  assign ar_done   = s_axi_arready && s_axi_arvalid && !s_axi_rvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_arready <= 1'b0;
    end else begin
      s_axi_arready <= ar_accept;            // Single cycle pulse
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_accept) begin
      rd_index <= s_axi_araddr[addr_lsb +: reg_index_width];
    end
  end

  // RDATA only moves when a read is accepted, so it holds during a stall
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_rvalid <= 1'b0;
      s_axi_rdata  <= '0;
    end else if (ar_done) begin
      s_axi_rvalid <= 1'b1;
      s_axi_rdata  <= rd_data;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  assign s_axi_rresp = resp_okay;

endmodule

`default_nettype wire

/* design/axi_regs_top.sv */
`default_nettype none

module axi_regs_top (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,

  input  axi_regs_pkg::addr_t     s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  axi_regs_pkg::data_t     s_axi_wdata,
  input  axi_regs_pkg::strb_t     s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output axi_regs_pkg::axi_resp_e s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,

  input  axi_regs_pkg::addr_t     s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output axi_regs_pkg::data_t     s_axi_rdata,
  output axi_regs_pkg::axi_resp_e s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready
);

  import axi_regs_pkg::*;

  // Write stage to bank
  logic       wr_en;
  reg_index_t wr_index;
  data_t      wr_data;
  strb_t      wr_strb;

  // Read stage to bank
  reg_index_t rd_index;
  data_t      rd_data;

  reg_write_channel u_write (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  reg_bank u_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

  reg_read_channel u_read (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

endmodule

`default_nettype wire

/* testbench/tb_axi_regs.sv */
`default_nettype none

module tb_axi_regs;

  import axi_regs_pkg::*;

  localparam int          clk_period  = 20;
  localparam int          drive_delay = 2;
  localparam int          wait_limit  = 50;    // Cycles per handshake wait
  localparam int          num_random  = 200;
  localparam logic [31:0] seed        = 32'h15121a76;

  logic      S_AXI_ACLK;
  logic      S_AXI_ARESETN;
  addr_t     s_axi_awaddr;
  logic      s_axi_awvalid;
  logic      s_axi_awready;
  data_t     s_axi_wdata;
  strb_t     s_axi_wstrb;
  logic      s_axi_wvalid;
  logic      s_axi_wready;
  axi_resp_e s_axi_bresp;
  logic      s_axi_bvalid;
  logic      s_axi_bready;
  addr_t     s_axi_araddr;
  logic      s_axi_arvalid;
  logic      s_axi_arready;
  data_t     s_axi_rdata;
  axi_resp_e s_axi_rresp;
  logic      s_axi_rvalid;
  logic      s_axi_rready;

  logic [31:0] lfsr;
  data_t       model [num_regs];
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  axi_regs_top UUT (.*);

  always #(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Byte lanes with a set strobe take the new data
  function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[b*8 +: 8] = data[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic step();
    @(posedge S_AXI_ACLK);
    #(drive_delay);
  endtask

  // Waits out the AW/W handshake and returns with BVALID high
  task automatic complete_write();
    int n;
    n = 0;
    while (!s_axi_awready) begin
      if (n == wait_limit) abort_run("Write address handshake timed out, AWREADY never rose");
      step();
      n++;
    end
    check_value("s_axi_wready", 1, s_axi_wready);
    step();                                    // Both handshakes complete here
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    while (!s_axi_bvalid) begin
      if (n == wait_limit) abort_run("Write response timed out, BVALID never rose");
      step();
      n++;
    end
    check_value("s_axi_bresp", resp_okay, s_axi_bresp);
  endtask

  task automatic start_write(input addr_t addr, input data_t data, input strb_t strb);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    complete_write();
  endtask

  task automatic finish_write(input int delay);
    repeat (delay) begin
      step();
      check_value("s_axi_bvalid", 1, s_axi_bvalid);
    end
    s_axi_bready = 1'b1;
    step();
    s_axi_bready = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb,
                           input int delay);
    start_write(addr, data, strb);
    finish_write(delay);
    model[addr[6:2]] = merge_bytes(model[addr[6:2]], data, strb);
  endtask

  // Returns with RVALID high and the read word captured
  task automatic start_read(input addr_t addr, output data_t data);
    int n;
    n = 0;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready) begin
      if (n == wait_limit) abort_run("Read address handshake timed out, ARREADY never rose");
      step();
      n++;
    end
    step();
    s_axi_arvalid = 1'b0;
    n = 0;
    while (!s_axi_rvalid) begin
      if (n == wait_limit) abort_run("Read data timed out, RVALID never rose");
      step();
      n++;
    end
    data = s_axi_rdata;
    check_value("s_axi_rresp", resp_okay, s_axi_rresp);
  endtask

  task automatic finish_read(input int delay, input data_t data);
    repeat (delay) begin                       // RDATA must hold while stalled
      step();
      check_value("s_axi_rvalid", 1, s_axi_rvalid);
      check_value("s_axi_rdata", data, s_axi_rdata);
    end
    s_axi_rready = 1'b1;
    step();
    s_axi_rready = 1'b0;
  endtask

  task automatic read_reg(input addr_t addr, input int delay, output data_t data);
    start_read(addr, data);
    finish_read(delay, data);
  endtask

  task automatic read_check(input addr_t addr, input int delay);
    data_t data;
    read_reg(addr, delay, data);
    check_value("s_axi_rdata", model[addr[6:2]], data);
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("[%s] passed", name);
    end else begin
      tests_failed++;
      $display("[%s] failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    addr_t      addr;
    reg_index_t idx;
    strb_t      strb;
    data_t      rd_word;

    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    lfsr          = seed;
    test_errors   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    for (int i = 0; i < num_regs; i++) model[i] = '0;

    repeat (8) @(posedge S_AXI_ACLK);
    #(drive_delay);
    S_AXI_ARESETN = 1'b1;

    for (int i = 0; i < num_regs; i++) read_check(addr_t'(i * 4), 0);
    end_test("reset");

    repeat (20) begin
      addr = rand_bits(7);
      write_reg(addr, rand_bits(32), 4'hf, rand_bits(2));
      read_check(addr, rand_bits(2));
    end
    end_test("full word");

    repeat (20) begin
      addr = rand_bits(7);
      write_reg(addr, rand_bits(32), rand_bits(4), rand_bits(2));
      read_check(addr, 0);
    end
    end_test("byte strobes");

    repeat (8) begin
      idx = rand_bits(5);
      write_reg({idx, 2'(rand_bits(2))}, rand_bits(32), 4'hf, 0);
      read_check({idx, 2'(rand_bits(2))}, 0);          // Low bits differ on purpose
      write_reg({idx, 2'b11}, rand_bits(32), 4'b0110, 0);
      read_check({idx, 2'b00}, 0);
    end
    end_test("address aliasing");

    idx  = rand_bits(5);
    strb = rand_bits(4) | 4'b0001;
    start_write({idx, 2'b00}, rand_bits(32), 4'hf);
    model[idx] = s_axi_wdata;                            // Bank holds the first write
    s_axi_awaddr  = {idx, 2'(rand_bits(2))};
    s_axi_wdata   = rand_bits(32);
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    repeat (4) begin
      step();
      check_value("s_axi_awready", 0, s_axi_awready);
      check_value("s_axi_wready", 0, s_axi_wready);
      check_value("s_axi_bvalid", 1, s_axi_bvalid);
    end
    s_axi_bready = 1'b1;                                 // Releases the first response
    step();
    s_axi_bready = 1'b0;
    complete_write();
    model[idx] = merge_bytes(model[idx], s_axi_wdata, strb);
    finish_write(0);
    read_check({idx, 2'b00}, 0);
    end_test("write back-pressure");

    idx = rand_bits(5);
    start_read({idx, 2'b00}, rd_word);
    check_value("s_axi_rdata", model[idx], rd_word);
    write_reg({idx, 2'b00}, ~model[idx], 4'hf, 0);      // Bank word changes under the stall
    finish_read(5, rd_word);
    read_check({idx, 2'b00}, 0);
    for (int i = 0; i < num_random; i++) begin
      addr = rand_bits(7);
      if (rand_bits(1)) write_reg(addr, rand_bits(32), rand_bits(4), rand_bits(2));
      else read_check(addr, rand_bits(2));
    end
    end_test("read back-pressure and random mix");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
design/axi_regs_pkg.sv
design/reg_write_channel.sv
design/reg_bank.sv
design/reg_read_channel.sv
design/axi_regs_top.sv
testbench/tb_axi_regs.sv

/* Bender.yml */
package:
  name: axi_regs

sources:
  - design/axi_regs_pkg.sv
  - design/reg_write_channel.sv
  - design/reg_bank.sv
  - design/reg_read_channel.sv
  - design/axi_regs_top.sv
  - target: test
    files:
      - testbench/tb_axi_regs.sv
